//--- verilog/axi_pkg.sv
`default_nettype none

package axi_pkg;

    localparam int AXI_DATA_W  = 32;
    localparam int AXI_ADDR_W  = 32;
    localparam int AXI_LEN_W   = 4;
    localparam int AXI_STRB_W  = AXI_DATA_W / 8;
    localparam int AXI_SIZE_W  = 3;
    localparam int AXI_BURST_W = 2;

    // Length field holds beats minus one
    localparam logic [AXI_LEN_W-1:0]   AXI_LEN_ONE    = 4'd0;
    localparam logic [AXI_LEN_W-1:0]   AXI_LEN_LINE   = 4'd3;
    localparam logic [AXI_SIZE_W-1:0]  AXI_SIZE_WORD  = 3'd2;
    localparam logic [AXI_BURST_W-1:0] AXI_BURST_INCR = 2'd1;

    // Master channel states
    localparam logic [2:0] ST_IDLE = 3'd0;
    localparam logic [2:0] ST_AR   = 3'd1;
    localparam logic [2:0] ST_R    = 3'd2;
    localparam logic [2:0] ST_AW   = 3'd3;
    localparam logic [2:0] ST_W    = 3'd4;
    localparam logic [2:0] ST_B    = 3'd5;

endpackage

`default_nettype wire

//--- verilog/cache_pkg.sv
`default_nettype none

package cache_pkg;

    localparam int LINES          = 16;
    localparam int WORDS_PER_LINE = 4;
    localparam int INDEX_W        = 4;
    localparam int TAG_W          = 24;
    localparam int WTYPE_W        = 2;

    localparam logic [WTYPE_W-1:0] WTYPE_BYTE = 2'd0;
    localparam logic [WTYPE_W-1:0] WTYPE_HALF = 2'd1;
    localparam logic [WTYPE_W-1:0] WTYPE_WORD = 2'd2;

    // Cache controller states
    localparam logic [2:0] CS_IDLE  = 3'd0;
    localparam logic [2:0] CS_FILL  = 3'd1;
    localparam logic [2:0] CS_RDONE = 3'd2;
    localparam logic [2:0] CS_WRITE = 3'd3;
    localparam logic [2:0] CS_WDONE = 3'd4;

    // A stored tag is the uncached flag followed by the tag field
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic                                uncached;
            logic [TAG_W-2:0]                    tag;
            logic [INDEX_W-1:0]                  index;
            logic [$clog2(WORDS_PER_LINE)-1:0]   word_off;
            logic [1:0]                          byte_off;
        } fld;
    } cpu_addr_u;

endpackage

`default_nettype wire

//--- verilog/axi_master.sv
`default_nettype none

module axi_master import axi_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    // Cache side
    input  logic                   rd_req_i,
    input  logic                   wr_req_i,
    input  logic                   single_beat_i,
    input  logic [AXI_ADDR_W-1:0]  addr_i,
    input  logic [AXI_DATA_W-1:0]  wdata_i,
    input  logic [AXI_STRB_W-1:0]  wstrb_i,
    output logic [AXI_DATA_W-1:0]  rdata_o,
    output logic                   beat_valid_o,
    output logic                   busy_o,
    // Read channels
    output logic                   arvalid_o,
    output logic [AXI_ADDR_W-1:0]  araddr_o,
    output logic [AXI_LEN_W-1:0]   arlen_o,
    output logic [AXI_SIZE_W-1:0]  arsize_o,
    output logic [AXI_BURST_W-1:0] arburst_o,
    input  logic                   arready_i,
    input  logic                   rvalid_i,
    input  logic [AXI_DATA_W-1:0]  rdata_i,
    input  logic                   rlast_i,
    output logic                   rready_o,
    // Write channels
    output logic                   awvalid_o,
    output logic [AXI_ADDR_W-1:0]  awaddr_o,
    output logic [AXI_LEN_W-1:0]   awlen_o,
    output logic [AXI_SIZE_W-1:0]  awsize_o,
    output logic [AXI_BURST_W-1:0] awburst_o,
    input  logic                   awready_i,
    output logic                   wvalid_o,
    output logic [AXI_DATA_W-1:0]  wdata_o,
    output logic [AXI_STRB_W-1:0]  wstrb_o,
    output logic                   wlast_o,
    input  logic                   wready_i,
    input  logic                   bvalid_i,
    output logic                   bready_o
);

    logic [2:0] state_q;
    logic [2:0] state_d;
    logic       ar_hs;
    logic       aw_hs;
    logic       w_hs;
    logic       b_hs;
    logic       r_last;

    assign ar_hs  = arvalid_o & arready_i;
    assign aw_hs  = awvalid_o & awready_i;
    assign w_hs   = wvalid_o & wready_i;
    assign b_hs   = bvalid_i & bready_o;
    assign r_last = rvalid_i & rready_o & rlast_i;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            state_q <= ST_IDLE;
        else
            state_q <= state_d;
    end

    // Reads win when both requests are up
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (rd_req_i)
                    state_d = ST_AR;
                else if (wr_req_i)
                    state_d = ST_AW;
            end
            ST_AR:   if (ar_hs) state_d = ST_R;
            ST_R:    if (r_last) state_d = ST_IDLE;
            ST_AW:   if (aw_hs) state_d = ST_W;
            ST_W:    if (w_hs) state_d = ST_B;
            ST_B:    if (b_hs) state_d = ST_IDLE;
            default: state_d = ST_IDLE;
        endcase
    end

    // Busy drops in the completing cycle
    always_comb begin
        case (state_q)
            ST_IDLE: busy_o = rd_req_i | wr_req_i;
            ST_R:    busy_o = ~r_last;
            ST_B:    busy_o = ~b_hs;
            default: busy_o = 1'b1;
        endcase
    end

    assign arvalid_o = state_q == ST_AR;
    assign araddr_o  = addr_i;
    assign arlen_o   = single_beat_i ? AXI_LEN_ONE : AXI_LEN_LINE;
    assign arsize_o  = AXI_SIZE_WORD;
    assign arburst_o = AXI_BURST_INCR;
    assign rready_o  = state_q == ST_R;

    assign awvalid_o = state_q == ST_AW;
    assign awaddr_o  = addr_i;
    assign awlen_o   = AXI_LEN_ONE;
    assign awsize_o  = AXI_SIZE_WORD;
    assign awburst_o = AXI_BURST_INCR;
    assign wvalid_o  = state_q == ST_W;
    assign wdata_o   = wdata_i;
    assign wstrb_o   = wstrb_i;
    assign wlast_o   = 1'b1;
    assign bready_o  = state_q == ST_B;

    assign rdata_o      = rdata_i;
    assign beat_valid_o = rvalid_i & rready_o;

endmodule

`default_nettype wire

//--- verilog/dcache.sv
`default_nettype none

module dcache import cache_pkg::*, axi_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    // CPU side
    input  logic                  req_i,
    input  logic                  write_i,
    input  logic [WTYPE_W-1:0]    wtype_i,
    input  cpu_addr_u             addr_i,
    input  logic [AXI_DATA_W-1:0] wdata_i,
    output logic [AXI_DATA_W-1:0] rdata_o,
    output logic                  stall_o,
    // Master side
    output logic                  rd_req_o,
    output logic                  wr_req_o,
    output logic                  single_beat_o,
    output logic [AXI_ADDR_W-1:0] mem_addr_o,
    output logic [AXI_DATA_W-1:0] mem_wdata_o,
    output logic [AXI_STRB_W-1:0] wstrb_o,
    input  logic [AXI_DATA_W-1:0] mem_rdata_i,
    input  logic                  beat_valid_i,
    input  logic                  busy_i
);

    logic [2:0]            state_q;
    logic [2:0]            state_d;
    logic [LINES-1:0]      valid_q;
    logic [TAG_W-1:0]      tag_ram [LINES];
    logic [AXI_DATA_W-1:0] data_ram [LINES][WORDS_PER_LINE];
    logic [AXI_DATA_W-1:0] unc_rdata_q;
    logic [1:0]            beat_cnt_q;
    logic [INDEX_W-1:0]    idx;
    logic [1:0]            word;
    logic [TAG_W-1:0]      tag;
    logic                  uncached;
    logic                  hit;
    logic                  last_beat;
    logic [AXI_STRB_W-1:0] strb_base;

    assign idx       = addr_i.fld.index;
    assign word      = addr_i.fld.word_off;
    assign uncached  = addr_i.fld.uncached;
    assign tag       = {uncached, addr_i.fld.tag};
    assign hit       = valid_q[idx] & (tag_ram[idx] == tag) & ~uncached;
    assign last_beat = beat_valid_i & ~busy_i;

    always_comb begin
        case (wtype_i)
            WTYPE_BYTE: strb_base = 4'b0001;
            WTYPE_HALF: strb_base = 4'b0011;
            WTYPE_WORD: strb_base = 4'b1111;
            default:    strb_base = 4'b1111;
        endcase
    end

    // CPU data is low aligned, move it to its byte lanes
    assign wstrb_o     = strb_base << addr_i.fld.byte_off;
    assign mem_wdata_o = wdata_i << {addr_i.fld.byte_off, 3'b000};

    // Fills start at the line base
    assign mem_addr_o    = (write_i | uncached) ? {addr_i.raw[31:2], 2'b00}
                                                : {addr_i.raw[31:4], 4'b0000};
    assign single_beat_o = uncached;
    assign rd_req_o      = state_q == CS_FILL;
    assign wr_req_o      = state_q == CS_WRITE;
    assign rdata_o       = uncached ? unc_rdata_q : data_ram[idx][word];

    always_comb begin
        state_d = state_q;
        stall_o = 1'b1;
        case (state_q)
            CS_IDLE: begin
                stall_o = req_i & (write_i | ~hit);
                if (req_i && write_i)
                    state_d = CS_WRITE;
                else if (req_i && !hit)
                    state_d = CS_FILL;
            end
            CS_FILL:  if (last_beat) state_d = CS_RDONE;
            CS_WRITE: if (!busy_i) state_d = CS_WDONE;
            default: begin
                stall_o = 1'b0;
                state_d = CS_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q    <= CS_IDLE;
            valid_q    <= '0;
            beat_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == CS_FILL && beat_valid_i)
                beat_cnt_q <= beat_cnt_q + 2'd1;
            else if (state_q == CS_IDLE)
                beat_cnt_q <= '0;
            if (state_q == CS_FILL && last_beat && !uncached)
                valid_q[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == CS_FILL && beat_valid_i) begin
            if (uncached)
                unc_rdata_q <= mem_rdata_i;
            else
                data_ram[idx][beat_cnt_q] <= mem_rdata_i;
        end
        if (state_q == CS_FILL && last_beat && !uncached)
            tag_ram[idx] <= tag;
        // Write hit updates the cached copy
        if (state_q == CS_IDLE && req_i && write_i && hit) begin
            for (int b = 0; b < AXI_STRB_W; b++) begin
                if (wstrb_o[b])
                    data_ram[idx][word][8*b +: 8] <= mem_wdata_o[8*b +: 8];
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/axi_sram.sv
`default_nettype none

module axi_sram import axi_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   arvalid_i,
    input  logic [AXI_ADDR_W-1:0]  araddr_i,
    input  logic [AXI_LEN_W-1:0]   arlen_i,
    input  logic [AXI_SIZE_W-1:0]  arsize_i,
    input  logic [AXI_BURST_W-1:0] arburst_i,
    output logic                   arready_o,
    output logic                   rvalid_o,
    output logic [AXI_DATA_W-1:0]  rdata_o,
    output logic                   rlast_o,
    input  logic                   rready_i,
    input  logic                   awvalid_i,
    input  logic [AXI_ADDR_W-1:0]  awaddr_i,
    input  logic [AXI_LEN_W-1:0]   awlen_i,
    input  logic [AXI_SIZE_W-1:0]  awsize_i,
    input  logic [AXI_BURST_W-1:0] awburst_i,
    output logic                   awready_o,
    input  logic                   wvalid_i,
    input  logic [AXI_DATA_W-1:0]  wdata_i,
    input  logic [AXI_STRB_W-1:0]  wstrb_i,
    input  logic                   wlast_i,
    output logic                   wready_o,
    output logic                   bvalid_o,
    input  logic                   bready_i
);

    logic [AXI_DATA_W-1:0] mem [1024];
    logic                  rd_act_q;
    logic                  wr_act_q;
    logic                  b_pend_q;
    logic [11:0]           addr_q;
    logic [11:0]           step_q;
    logic                  incr_q;
    logic [AXI_LEN_W-1:0]  cnt_q;
    logic                  idle;
    logic                  r_hs;
    logic                  w_hs;
    logic                  w_end;

    assign idle      = ~(rd_act_q | wr_act_q | b_pend_q);
    assign arready_o = idle;
    assign awready_o = idle & ~arvalid_i;
    assign rvalid_o  = rd_act_q;
    assign rdata_o   = mem[addr_q[11:2]];
    assign rlast_o   = rd_act_q & (cnt_q == '0);
    assign wready_o  = wr_act_q;
    assign bvalid_o  = b_pend_q;

    assign r_hs  = rvalid_o & rready_i;
    assign w_hs  = wvalid_i & wready_o;
    assign w_end = w_hs & (wlast_i | (cnt_q == '0));

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rd_act_q <= 1'b0;
            wr_act_q <= 1'b0;
            b_pend_q <= 1'b0;
            addr_q   <= '0;
            step_q   <= '0;
            incr_q   <= 1'b0;
            cnt_q    <= '0;
        end else begin
            if (arvalid_i && arready_o) begin
                rd_act_q <= 1'b1;
                addr_q   <= araddr_i[11:0];
                step_q   <= 12'd1 << arsize_i;
                incr_q   <= arburst_i == AXI_BURST_INCR;
                cnt_q    <= arlen_i;
            end else if (awvalid_i && awready_o) begin
                wr_act_q <= 1'b1;
                addr_q   <= awaddr_i[11:0];
                step_q   <= 12'd1 << awsize_i;
                incr_q   <= awburst_i == AXI_BURST_INCR;
                cnt_q    <= awlen_i;
            end
            // Advance one beat
            if (r_hs || w_hs) begin
                if (incr_q)
                    addr_q <= addr_q + step_q;
                cnt_q <= cnt_q - 1'b1;
            end
            if (r_hs && rlast_o)
                rd_act_q <= 1'b0;
            if (w_end) begin
                wr_act_q <= 1'b0;
                b_pend_q <= 1'b1;
            end
            if (bvalid_o && bready_i)
                b_pend_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (w_hs) begin
            for (int b = 0; b < AXI_STRB_W; b++) begin
                if (wstrb_i[b])
                    mem[addr_q[11:2]][8*b +: 8] <= wdata_i[8*b +: 8];
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/mem_subsys_top.sv
`default_nettype none

module mem_subsys_top import axi_pkg::*, cache_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_i,
    input  logic                  write_i,
    input  logic [WTYPE_W-1:0]    wtype_i,
    input  logic [AXI_ADDR_W-1:0] addr_i,
    input  logic [AXI_DATA_W-1:0] wdata_i,
    output logic [AXI_DATA_W-1:0] rdata_o,
    output logic                  stall_o
);

    // Cache to master
    logic                   rd_req, wr_req, single_beat, beat_valid, busy;
    logic [AXI_ADDR_W-1:0]  mem_addr;
    logic [AXI_DATA_W-1:0]  mem_wdata, mem_rdata;
    logic [AXI_STRB_W-1:0]  mem_wstrb;

    // AXI channels
    logic                   arvalid, arready, rvalid, rready, rlast;
    logic                   awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    logic [AXI_ADDR_W-1:0]  araddr, awaddr;
    logic [AXI_LEN_W-1:0]   arlen, awlen;
    logic [AXI_SIZE_W-1:0]  arsize, awsize;
    logic [AXI_BURST_W-1:0] arburst, awburst;
    logic [AXI_DATA_W-1:0]  rdata, wdata;
    logic [AXI_STRB_W-1:0]  wstrb;

    dcache u_dcache (
        .clk(clk), .rst(rst),
        .req_i(req_i), .write_i(write_i), .wtype_i(wtype_i),
        .addr_i(addr_i), .wdata_i(wdata_i), .rdata_o(rdata_o), .stall_o(stall_o),
        .rd_req_o(rd_req), .wr_req_o(wr_req), .single_beat_o(single_beat),
        .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata), .wstrb_o(mem_wstrb),
        .mem_rdata_i(mem_rdata), .beat_valid_i(beat_valid), .busy_i(busy)
    );

    axi_master u_axi_master (
        .clk(clk), .rst(rst),
        .rd_req_i(rd_req), .wr_req_i(wr_req), .single_beat_i(single_beat),
        .addr_i(mem_addr), .wdata_i(mem_wdata), .wstrb_i(mem_wstrb),
        .rdata_o(mem_rdata), .beat_valid_o(beat_valid), .busy_o(busy),
        .arvalid_o(arvalid), .araddr_o(araddr), .arlen_o(arlen),
        .arsize_o(arsize), .arburst_o(arburst), .arready_i(arready),
        .rvalid_i(rvalid), .rdata_i(rdata), .rlast_i(rlast), .rready_o(rready),
        .awvalid_o(awvalid), .awaddr_o(awaddr), .awlen_o(awlen),
        .awsize_o(awsize), .awburst_o(awburst), .awready_i(awready),
        .wvalid_o(wvalid), .wdata_o(wdata), .wstrb_o(wstrb), .wlast_o(wlast),
        .wready_i(wready), .bvalid_i(bvalid), .bready_o(bready)
    );

    axi_sram u_axi_sram (
        .clk(clk), .rst(rst),
        .arvalid_i(arvalid), .araddr_i(araddr), .arlen_i(arlen),
        .arsize_i(arsize), .arburst_i(arburst), .arready_o(arready),
        .rvalid_o(rvalid), .rdata_o(rdata), .rlast_o(rlast), .rready_i(rready),
        .awvalid_i(awvalid), .awaddr_i(awaddr), .awlen_i(awlen),
        .awsize_i(awsize), .awburst_i(awburst), .awready_o(awready),
        .wvalid_i(wvalid), .wdata_i(wdata), .wstrb_i(wstrb), .wlast_i(wlast),
        .wready_o(wready), .bvalid_o(bvalid), .bready_i(bready)
    );

endmodule

`default_nettype wire

//--- verification/mem_subsys_checker.sv
`default_nettype none

module mem_subsys_checker (
    input logic clk_i,
    input logic rst_i,
    input logic stall_i,
    input logic arvalid_i,
    input logic arready_i,
    input logic awvalid_i,
    input logic awready_i,
    input logic wvalid_i,
    input logic wready_i,
    input logic rvalid_i,
    input logic rlast_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // Master valids hold until accepted
    ar_hold: assert property (@(posedge clk_i) disable iff (!rst_i)
        arvalid_i && !arready_i |=> arvalid_i)
        else $error("arvalid dropped before arready");

    aw_hold: assert property (@(posedge clk_i) disable iff (!rst_i)
        awvalid_i && !awready_i |=> awvalid_i)
        else $error("awvalid dropped before awready");

    w_hold: assert property (@(posedge clk_i) disable iff (!rst_i)
        wvalid_i && !wready_i |=> wvalid_i)
        else $error("wvalid dropped before wready");

    stall_in_reset: assert property (@(posedge clk_i) !rst_i |-> !stall_i)
        else $error("stall_o high while in reset");

    stall_at_release: assert property (@(posedge clk_i) $rose(rst_i) |-> !stall_i)
        else $error("stall_o high at reset release");

    rlast_with_rvalid: assert property (@(posedge clk_i) disable iff (!rst_i)
        rlast_i |-> rvalid_i)
        else $error("rlast without rvalid");

endmodule

`default_nettype wire

//--- verification/mem_subsys_tb.sv
`default_nettype none

module mem_subsys_tb import cache_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    logic               clk;
    logic               rst;
    logic               req;
    logic               wr;
    logic [WTYPE_W-1:0] wtype;
    logic [31:0]        addr;
    logic [31:0]        wdata;
    logic [31:0]        rdata;
    logic               stall;

    logic [7:0]         op_q[$];
    logic [WTYPE_W-1:0] wt_q[$];
    logic [31:0]        addr_q[$];
    logic [31:0]        wdata_q[$];
    logic [31:0]        exp_q[$];
    logic [7:0]         model_mem [4096];
    bit                 line_valid [16];
    logic [23:0]        line_tag [16];
    int                 n_tests;
    int                 n_errors;
    bit                 loaded;

    mem_subsys_top u_mem_subsys_top (
        .clk(clk), .rst(rst), .req_i(req), .write_i(wr), .wtype_i(wtype),
        .addr_i(addr), .wdata_i(wdata), .rdata_o(rdata), .stall_o(stall)
    );

    bind mem_subsys_top mem_subsys_checker u_checker (
        .clk_i(clk), .rst_i(rst), .stall_i(stall_o),
        .arvalid_i(arvalid), .arready_i(arready),
        .awvalid_i(awvalid), .awready_i(awready),
        .wvalid_i(wvalid), .wready_i(wready),
        .rvalid_i(rvalid), .rlast_i(rlast)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Lines that do not parse into five fields are comments
    task automatic load_tests(output bit ok);
        int          fd;
        string       line;
        logic [7:0]  op;
        logic [31:0] wt;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        fd = $fopen("verification/mem_subsys_tests.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) > 0) begin
                    if ($sscanf(line, "%s %d %h %h %h", op, wt, a, d, e) == 5) begin
                        op_q.push_back(op);
                        wt_q.push_back(wt[WTYPE_W-1:0]);
                        addr_q.push_back(a);
                        wdata_q.push_back(d);
                        exp_q.push_back(e);
                    end
                end
            end
            $fclose(fd);
            n_tests = op_q.size();
        end
    endtask

    // Byte i of the low aligned CPU data lands at address + i
    function automatic void model_write(logic [31:0] a, logic [WTYPE_W-1:0] wt, logic [31:0] d);
        int nbytes;
        int base;
        nbytes = (wt == WTYPE_BYTE) ? 1 : (wt == WTYPE_HALF) ? 2 : 4;
        base = int'(a[11:0]);
        for (int i = 0; i < nbytes; i++)
            model_mem[(base + i) % 4096] = d[8*i +: 8];
    endfunction

    // Memory aliases every 4 KB including bit 31
    function automatic logic [31:0] model_read(logic [31:0] a);
        int w;
        w = int'({a[11:2], 2'b00});
        return {model_mem[w+3], model_mem[w+2], model_mem[w+1], model_mem[w]};
    endfunction

    // Tag model of the direct-mapped cache where only cached reads allocate
    function automatic bit model_lookup(logic [31:0] a);
        bit hit;
        hit = !a[31] && line_valid[a[7:4]] && (line_tag[a[7:4]] == a[31:8]);
        if (!a[31]) begin
            line_valid[a[7:4]] = 1'b1;
            line_tag[a[7:4]]   = a[31:8];
        end
        return hit;
    endfunction

    task automatic reset_dut();
        rst = 1'b0;
        repeat (8) begin
            @(posedge clk);
            if (stall !== 1'b0) begin
                n_errors++;
                $display("Error at %0t: stall_o is %b during reset", $time, stall);
            end
        end
        @(negedge clk);
        rst = 1'b1;
        @(posedge clk);
        if (stall !== 1'b0) begin
            n_errors++;
            $display("Error at %0t: stall_o is %b after reset", $time, stall);
        end else begin
            $display("reset: stall_o low during and after reset");
        end
    endtask

    task automatic run_test(int i);
        bit          is_write;
        bit          want_hit;
        int          cycles;
        logic [31:0] got;
        logic [31:0] want;
        is_write = (op_q[i] == "W");
        cycles   = 0;
        @(negedge clk);
        req   = 1'b1;
        wr    = is_write;
        wtype = wt_q[i];
        addr  = addr_q[i];
        wdata = wdata_q[i];
        // Completion is the edge that sees stall_o low
        do begin
            @(posedge clk);
            cycles++;
        end while (stall !== 1'b0);
        got = rdata;
        @(negedge clk);
        req = 1'b0;
        if (is_write) begin
            model_write(addr_q[i], wt_q[i], wdata_q[i]);
            $display("test %0d: write %h type %0d data %h done", i, addr_q[i], wt_q[i],
                     wdata_q[i]);
        end else begin
            want     = model_read(addr_q[i]);
            want_hit = model_lookup(addr_q[i]);
            if (want !== exp_q[i]) begin
                n_errors++;
                $display("Error at %0t: test %0d file expects %h but memory model holds %h",
                         $time, i, exp_q[i], want);
            end else if (got !== want) begin
                n_errors++;
                $display("Error at %0t: test %0d read %h expected %h got %h",
                         $time, i, addr_q[i], want, got);
            end else if (want_hit != (cycles == 1)) begin
                n_errors++;
                $display("Error at %0t: test %0d read %h expected a %s but took %0d cycles",
                         $time, i, addr_q[i], want_hit ? "hit" : "miss", cycles);
            end else begin
                $display("test %0d: read %h = %h ok", i, addr_q[i], got);
            end
        end
    endtask

    initial begin
        bit ok;
        rst      = 1'b0;
        req      = 1'b0;
        wr       = 1'b0;
        wtype    = WTYPE_WORD;
        addr     = '0;
        wdata    = '0;
        n_tests  = 0;
        n_errors = 0;
        load_tests(ok);
        if (!ok) begin
            $display("Could not open verification/mem_subsys_tests.txt");
            $display("STATUS: FAIL");
            $finish;
        end else begin
            loaded = 1'b1;
            reset_dut();
            for (int i = 0; i < n_tests; i++)
                run_test(i);
            $display("Summary: %0d tests run, %0d errors", n_tests, n_errors);
            if (n_errors == 0) begin
                $display("STATUS: PASS");
            end else begin
                $display("STATUS: FAIL");
            end
            $finish;
        end
    end

    // Budget of 100 cycles per operation
    initial begin
        wait (loaded);
        repeat (n_tests * 100) @(posedge clk);
        $display("Timeout: the DUT did not finish %0d tests within %0d cycles",
                 n_tests, n_tests * 100);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/mem_subsys_tests.txt
# op wtype addr wdata expected
# op R or W; wtype 0 byte, 1 half, 2 word; hex values; expected is used by reads only
W 2 00000100 11223344 00000000
W 2 00000104 55667788 00000000
W 2 00000108 99aabbcc 00000000
W 2 0000010c ddeeff00 00000000
R 0 00000100 00000000 11223344
R 0 00000108 00000000 99aabbcc
W 0 00000101 000000a5 00000000
R 0 00000100 00000000 1122a544
W 0 00000103 0000005a 00000000
W 0 00000102 0000003c 00000000
W 0 00000100 0000007e 00000000
R 0 00000100 00000000 5a3ca57e
W 1 00000106 0000beef 00000000
W 1 00000104 0000cafe 00000000
R 0 00000104 00000000 beefcafe
R 0 0000010c 00000000 ddeeff00
W 2 00000020 01020304 00000000
W 0 00000022 000000ff 00000000
R 0 80000020 00000000 01ff0304
R 0 00000020 00000000 01ff0304
W 2 00000420 a0b0c0d0 00000000
R 0 00000420 00000000 a0b0c0d0
R 0 00000020 00000000 01ff0304
W 1 00000422 00001234 00000000
R 0 80000420 00000000 1234c0d0
R 0 00000420 00000000 1234c0d0

//--- mem_subsys.f
verilog/axi_pkg.sv
verilog/cache_pkg.sv
verilog/axi_master.sv
verilog/dcache.sv
verilog/axi_sram.sv
verilog/mem_subsys_top.sv
verification/mem_subsys_checker.sv
verification/mem_subsys_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f mem_subsys.f --top-module mem_subsys_tb -o mem_subsys_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/mem_subsys_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
exit 0
